/* Makefile */
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output"

test:
	verilator --binary --timing --assert -f filelist.f --top-module frontend_tb -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/Vfrontend_tb 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
+incdir+hdl
hdl/frontend_pkg.sv
hdl/fetch_unit.sv
hdl/instr_buffer.sv
hdl/instr_decoder.sv
hdl/issue_combiner.sv
hdl/frontend_top.sv
verification/frontend_sva.sv
verification/frontend_tb.sv

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps
`include "frontend_consts.svh"

module fetch_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall_i,
    input  logic                       flush_i,
    input  logic [31:0]                redirect_pc_i,
    input  logic                       imem_ack_i,
    input  logic [63:0]                imem_rdata_i,
    output logic                       imem_req_o,
    output logic [31:0]                imem_addr_o,
    output frontend_pkg::fetch_entry_t push_o [2]
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK_LOW,
        PUSH
    } fetch_state_e;

    fetch_state_e state_q;
    fetch_state_e state_d;
    logic [31:0]  pc_q;
    logic [31:0]  addr_q;
    logic [63:0]  rdata_q;
    logic         discard_q;
    logic         start_req;
    logic         push_ok;

    // New request needs ack low, buffer room and no redirect this cycle
    assign start_req = !stall_i && !imem_ack_i && !flush_i;

    // A flush in the push cycle itself drops the pair
    assign push_ok = (state_q == PUSH) && !discard_q && !flush_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_req) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (imem_ack_i) begin
                    state_d = PUSH;
                end
            end
            PUSH: begin
                state_d = WAIT_ACK_LOW;
            end
            WAIT_ACK_LOW: begin
                if (start_req) begin
                    state_d = REQ;
                end else if (!imem_ack_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            pc_q      <= `BOOT_PC;
            addr_q    <= `BOOT_PC;
            discard_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Address latched once, held stable for the whole request
            if (state_d == REQ && state_q != REQ) begin
                addr_q <= pc_q;
            end
            if (flush_i) begin
                pc_q <= redirect_pc_i;
            end else if (push_ok) begin
                pc_q <= pc_q + `FETCH_BYTES;
            end
            // Request still open at flush time, its data is stale
            if (flush_i && state_q == REQ) begin
                discard_q <= 1'b1;
            end else if (state_q == PUSH) begin
                discard_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == REQ && imem_ack_i) begin
            rdata_q <= imem_rdata_i;
        end
    end

    assign imem_req_o  = (state_q == REQ);
    assign imem_addr_o = addr_q;

    // Low word at addr, high word at addr + 4
    assign push_o[0].valid = push_ok;
    assign push_o[0].pc    = addr_q;
    assign push_o[0].instr = rdata_q[31:0];
    assign push_o[1].valid = push_ok;
    assign push_o[1].pc    = addr_q + 32'd4;
    assign push_o[1].instr = rdata_q[63:32];

endmodule

/* hdl/frontend_consts.svh */
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// First fetch address out of reset
`define BOOT_PC 32'h0000_0000

// Instruction buffer entries, power of two
`define IBUF_DEPTH 8

// Address step between two fetched pairs
`define FETCH_BYTES 32'd8

`endif

/* hdl/frontend_pkg.sv */
package frontend_pkg;

    // One fetched word with its address
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_entry_t;

    // Register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    // Register-immediate layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // Same instruction word seen as R or I format
    typedef union packed {
        r_fields_t r_view;
        i_fields_t i_view;
    } rv_instr_u;

    typedef enum logic [1:0] {
        R_ALU   = 2'd0,
        I_ALU   = 2'd1,
        ILLEGAL = 2'd2
    } instr_kind_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instr_kind_e kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        uses_rs2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] imm;
    } decoded_instr_t;

    // slot0 holds the older instruction
    typedef struct packed {
        decoded_instr_t slot1;
        decoded_instr_t slot0;
    } issue_bundle_t;

endpackage

/* hdl/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        imem_ack_i,
    input  logic [63:0]                 imem_rdata_i,
    input  logic                        issue_ready_i,
    input  logic                        flush_i,
    input  logic [31:0]                 redirect_pc_i,
    output logic                        imem_req_o,
    output logic [31:0]                 imem_addr_o,
    output frontend_pkg::issue_bundle_t issue_o
);

    import frontend_pkg::*;

    fetch_entry_t   push [2];
    fetch_entry_t   head [2];
    decoded_instr_t dec0;
    decoded_instr_t dec1;
    logic           stall;
    logic [1:0]     pop_cnt;

    fetch_unit fetch_unit_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_i       (stall),
        .flush_i       (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .imem_ack_i    (imem_ack_i),
        .imem_rdata_i  (imem_rdata_i),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .push_o        (push)
    );

    instr_buffer instr_buffer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push_i    (push),
        .pop_cnt_i (pop_cnt),
        .flush_i   (flush_i),
        .stall_o   (stall),
        .head_o    (head)
    );

    // Oldest entry feeds slot0
    instr_decoder dec0_i (
        .entry_i (head[0]),
        .dec_o   (dec0)
    );

    instr_decoder dec1_i (
        .entry_i (head[1]),
        .dec_o   (dec1)
    );

    issue_combiner issue_combiner_i (
        .dec0_i        (dec0),
        .dec1_i        (dec1),
        .issue_ready_i (issue_ready_i),
        .issue_o       (issue_o),
        .pop_cnt_o     (pop_cnt)
    );

endmodule

/* hdl/instr_buffer.sv */
`timescale 1ns/1ps
`include "frontend_consts.svh"

module instr_buffer #(
    parameter int DEPTH = `IBUF_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  frontend_pkg::fetch_entry_t push_i [2],
    input  logic [1:0]                 pop_cnt_i,
    input  logic                       flush_i,
    output logic                       stall_o,
    output frontend_pkg::fetch_entry_t head_o [2]
);

    import frontend_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_entry_t     mem_q [DEPTH];
    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] valid_d;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] wr_idx1;
    logic [PTR_W-1:0] head_idx [2];
    logic [CNT_W-1:0] count_q;
    logic [1:0]       push_cnt;

    assign push_cnt = {1'b0, push_i[0].valid} + {1'b0, push_i[1].valid};

    // Second word lands right behind the first one
    assign wr_idx1 = wr_ptr_q + PTR_W'(push_i[0].valid);

    // Stall while a full pair would not fit
    assign stall_o = (count_q > CNT_W'(DEPTH - 2));

    // Two oldest entries, visible without delay
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            head_idx[i]     = rd_ptr_q + PTR_W'(i);
            head_o[i]       = mem_q[head_idx[i]];
            head_o[i].valid = valid_q[head_idx[i]];
        end
    end

    always_comb begin
        valid_d = valid_q;
        for (int i = 0; i < 2; i++) begin
            if (2'(i) < pop_cnt_i) begin
                valid_d[head_idx[i]] = 1'b0;
            end
        end
        if (push_i[0].valid) begin
            valid_d[wr_ptr_q] = 1'b1;
        end
        if (push_i[1].valid) begin
            valid_d[wr_idx1] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            valid_q  <= '0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            valid_q  <= valid_d;
            rd_ptr_q <= rd_ptr_q + PTR_W'(pop_cnt_i);
            wr_ptr_q <= wr_ptr_q + PTR_W'(push_cnt);
            count_q  <= count_q + CNT_W'(push_cnt) - CNT_W'(pop_cnt_i);
        end
    end

    // Entry storage, words pushed during a flush are dropped
    always_ff @(posedge clk) begin
        if (!flush_i) begin
            if (push_i[0].valid) begin
                mem_q[wr_ptr_q] <= push_i[0];
            end
            if (push_i[1].valid) begin
                mem_q[wr_idx1] <= push_i[1];
            end
        end
    end

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  frontend_pkg::fetch_entry_t   entry_i,
    output frontend_pkg::decoded_instr_t dec_o
);

    import frontend_pkg::*;

    localparam logic [6:0] opc_r_alu = 7'b0110011;
    localparam logic [6:0] opc_i_alu = 7'b0010011;

    rv_instr_u word;

    assign word = entry_i.instr;

    always_comb begin
        dec_o       = '0;
        dec_o.valid = entry_i.valid;
        dec_o.pc    = entry_i.pc;
        case (word.r_view.opcode)
            opc_r_alu: begin
                dec_o.kind     = R_ALU;
                dec_o.rd       = word.r_view.rd;
                dec_o.rs1      = word.r_view.rs1;
                dec_o.rs2      = word.r_view.rs2;
                dec_o.uses_rs2 = 1'b1;
                dec_o.funct3   = word.r_view.funct3;
                dec_o.funct7   = word.r_view.funct7;
            end
            opc_i_alu: begin
                dec_o.kind   = I_ALU;
                dec_o.rd     = word.i_view.rd;
                dec_o.rs1    = word.i_view.rs1;
                dec_o.funct3 = word.i_view.funct3;
                // Sign extend the 12-bit immediate
                dec_o.imm    = {{20{word.i_view.imm12[11]}}, word.i_view.imm12};
            end
            default: begin
                // Unsupported opcodes go to the backend as ILLEGAL
                dec_o.kind = ILLEGAL;
            end
        endcase
    end

endmodule

/* hdl/issue_combiner.sv */
`timescale 1ns/1ps

module issue_combiner (
    input  frontend_pkg::decoded_instr_t dec0_i,
    input  frontend_pkg::decoded_instr_t dec1_i,
    input  logic                         issue_ready_i,
    output frontend_pkg::issue_bundle_t  issue_o,
    output logic [1:0]                   pop_cnt_o
);

    import frontend_pkg::*;

    logic dep_rs1;
    logic dep_rs2;
    logic slot1_dep;
    logic slot0_valid;
    logic slot1_valid;

    // Only a real destination can create a hazard
    assign dep_rs1   = (dec1_i.rs1 == dec0_i.rd);
    assign dep_rs2   = dec1_i.uses_rs2 && (dec1_i.rs2 == dec0_i.rd);
    assign slot1_dep = (dec0_i.kind != ILLEGAL) && (dec0_i.rd != 5'd0)
                       && (dep_rs1 || dep_rs2);

    assign slot0_valid = dec0_i.valid;

    // A dependent second word waits and issues next time as slot0
    assign slot1_valid = dec0_i.valid && dec1_i.valid && !slot1_dep;

    always_comb begin
        issue_o             = '0;
        issue_o.slot0       = dec0_i;
        issue_o.slot0.valid = slot0_valid;
        issue_o.slot1       = dec1_i;
        issue_o.slot1.valid = slot1_valid;
    end

    // Backend takes every valid slot when ready
    always_comb begin
        if (issue_ready_i) begin
            pop_cnt_o = {1'b0, slot0_valid} + {1'b0, slot1_valid};
        end else begin
            pop_cnt_o = 2'd0;
        end
    end

endmodule

/* verification/frontend_sva.sv */
`timescale 1ns/1ps
`include "frontend_consts.svh"

module frontend_sva (
    input logic        clk,
    input logic        rst_n,
    input logic        req,
    input logic        ack,
    input logic [3:0]  count,
    input logic        slot0_valid,
    input logic        slot1_valid,
    input logic [31:0] slot0_pc,
    input logic [31:0] slot1_pc
);

    // Request held until the memory answers
    assert property (@(posedge clk) disable iff (!rst_n) req && !ack |=> req)
        else $error("req dropped before ack");

    assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
        else $error("ack raised without req");

    assert property (@(posedge clk) disable iff (!rst_n) count <= 4'(`IBUF_DEPTH))
        else $error("buffer count above depth");

    // Second slot is the word right after the first
    assert property (@(posedge clk) disable iff (!rst_n)
        slot1_valid |-> slot0_valid && (slot1_pc == slot0_pc + 32'd4))
        else $error("slot1 valid without slot0 or not the next word");

endmodule

bind frontend_top frontend_sva frontend_sva_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (imem_req_o),
    .ack         (imem_ack_i),
    .count       (instr_buffer_i.count_q),
    .slot0_valid (issue_o.slot0.valid),
    .slot1_valid (issue_o.slot1.valid),
    .slot0_pc    (issue_o.slot0.pc),
    .slot1_pc    (issue_o.slot1.pc)
);

/* verification/frontend_tb.sv */
`timescale 1ns/1ps
`include "frontend_consts.svh"

module frontend_tb;

    import frontend_pkg::*;

    logic          clk;
    logic          rst_n;
    logic          imem_ack_i;
    logic [63:0]   imem_rdata_i;
    logic          issue_ready_i;
    logic          flush_i;
    logic [31:0]   redirect_pc_i;
    logic          imem_req_o;
    logic [31:0]   imem_addr_o;
    issue_bundle_t issue_o;

    logic          dep_mode;
    logic [31:0]   exp_pc;
    int            issued_cnt;
    int            dep_splits;
    int unsigned   seed_val;

    frontend_top frontend_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        stop_run();
    endtask

    // Word rule on index n: even n is addi, odd n is add
    function automatic logic [31:0] word_at(input logic [31:0] addr, input logic dep);
        logic [31:0] n;
        logic [4:0]  rs1;
        n = addr >> 2;
        if (!n[0]) begin
            return {n[11:0], 5'd0, 3'd0, n[4:0], 7'b0010011};
        end
        rs1 = dep ? 5'(n - 32'd1) : 5'd0;
        return {7'd0, 5'd0, rs1, 3'd0, n[4:0], 7'b0110011};
    endfunction

    task automatic check_slot(input decoded_instr_t s);
        logic [31:0] n;
        n = s.pc >> 2;
        check_eq(64'(s.pc), 64'(exp_pc), "issued pc");
        check_eq(64'(s.rd), 64'(n[4:0]), "rd");
        check_eq(64'(s.rs2), 64'd0, "rs2");
        check_eq(64'(s.funct3), 64'd0, "funct3");
        if (!n[0]) begin
            check_eq(64'(s.kind), 64'(I_ALU), "kind of even word");
            check_eq(64'(s.rs1), 64'd0, "rs1 of addi");
            check_eq(64'(s.uses_rs2), 64'd0, "uses_rs2 of addi");
            check_eq(64'(s.imm), 64'({{20{n[11]}}, n[11:0]}), "sign extended imm");
        end else begin
            check_eq(64'(s.kind), 64'(R_ALU), "kind of odd word");
            check_eq(64'(s.rs1), dep_mode ? 64'(5'(n - 32'd1)) : 64'd0, "rs1 of add");
            check_eq(64'(s.uses_rs2), 64'd1, "uses_rs2 of add");
            check_eq(64'(s.funct7), 64'd0, "funct7 of add");
            check_eq(64'(s.imm), 64'd0, "imm of add");
        end
        exp_pc = exp_pc + 32'd4;
        issued_cnt++;
    endtask

    // Instruction memory, four-phase with 0 to 3 cycles of delay
    initial begin
        int delay;
        int t;
        forever begin
            @(posedge clk);
            if (rst_n && imem_req_o && !imem_ack_i) begin
                delay = int'($urandom % 4);
                repeat (delay) @(posedge clk);
                imem_rdata_i <= {word_at(imem_addr_o + 32'd4, dep_mode),
                                 word_at(imem_addr_o, dep_mode)};
                imem_ack_i   <= 1'b1;
                t = 0;
                do begin
                    @(posedge clk);
                    t++;
                    if (t > 200) timed_out("req to drop in the memory model");
                end while (imem_req_o);
                imem_ack_i <= 1'b0;
            end
        end
    end

    // Issue monitor, the backend takes every valid slot when ready
    initial begin
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                exp_pc = `BOOT_PC;
            end else if (flush_i) begin
                exp_pc = redirect_pc_i;
            end else if (issue_ready_i && issue_o.slot0.valid) begin
                // Even word with a non-zero rd feeds rs1 of the odd word after it
                if (dep_mode && !issue_o.slot0.pc[2] && issue_o.slot0.pc[6:2] != 5'd0) begin
                    check_eq(64'(issue_o.slot1.valid), 64'd0, "slot1 valid despite dependency");
                    dep_splits++;
                end
                check_slot(issue_o.slot0);
                if (issue_o.slot1.valid) begin
                    check_slot(issue_o.slot1);
                end
            end
        end
    end

    task automatic wait_issued(input int n);
        int base;
        int t;
        base = issued_cnt;
        t = 0;
        while (issued_cnt < base + n) begin
            @(posedge clk);
            t++;
            if (t > 2000) timed_out("instructions to issue");
        end
    endtask

    // Called right after a rising edge
    task automatic flush_to(input logic [31:0] pc, input logic dep);
        flush_i       <= 1'b1;
        redirect_pc_i <= pc;
        dep_mode      <= dep;
        @(posedge clk);
        flush_i <= 1'b0;
    endtask

    task automatic reset_state();
        int t;
        check_eq(64'(imem_req_o), 64'd0, "req after reset");
        check_eq(64'(issue_o.slot0.valid), 64'd0, "slot0 valid after reset");
        check_eq(64'(issue_o.slot1.valid), 64'd0, "slot1 valid after reset");
        t = 0;
        while (!imem_req_o) begin
            @(posedge clk);
            t++;
            if (t > 50) timed_out("the first request");
        end
        check_eq(64'(imem_addr_o), 64'(`BOOT_PC), "first request address");
    endtask

    task automatic in_order_stream();
        issue_ready_i <= 1'b1;
        wait_issued(64);
    endtask

    task automatic dependency_split();
        flush_to(32'h0000_0040, 1'b1);
        wait_issued(64);
        check_eq(64'(dep_splits > 0), 64'd1, "dependency splits seen");
        flush_to(32'h0000_0400, 1'b0);
        wait_issued(16);
    endtask

    task automatic backpressure_hold();
        logic req_prev;
        logic stall_prev;
        issue_ready_i <= 1'b0;
        req_prev   = imem_req_o;
        stall_prev = frontend_top_i.stall;
        for (int i = 0; i < 40; i++) begin
            @(posedge clk);
            if (imem_req_o && !req_prev) begin
                check_eq(64'(stall_prev), 64'd0, "stall when req rose");
            end
            req_prev   = imem_req_o;
            stall_prev = frontend_top_i.stall;
        end
        check_eq(64'(frontend_top_i.stall), 64'd1, "stall with a full buffer");
        check_eq(64'(imem_req_o), 64'd0, "req with a full buffer");
        issue_ready_i <= 1'b1;
        wait_issued(32);
    endtask

    task automatic flush_redirect();
        int t;
        t = 0;
        while (!(imem_req_o && !imem_ack_i)) begin
            @(posedge clk);
            t++;
            if (t > 100) timed_out("an open handshake");
        end
        // Redirect into the upper half so imm12 turns negative
        flush_to(32'h0000_2000, 1'b0);
        wait_issued(16);
        // Push cycle just ended, so the flush meets no open request
        t = 0;
        while (imem_req_o || !imem_ack_i) begin
            @(posedge clk);
            t++;
            if (t > 100) timed_out("a push cycle");
        end
        flush_to(32'h0000_0100, 1'b0);
        wait_issued(16);
    endtask

    task automatic random_ready();
        for (int i = 0; i < 300; i++) begin
            @(posedge clk);
            issue_ready_i <= 1'($urandom % 2);
        end
        @(posedge clk);
        issue_ready_i <= 1'b1;
        wait_issued(16);
    endtask

    initial begin
        seed_val      = $urandom(30);
        issued_cnt    = 0;
        dep_splits    = 0;
        exp_pc        = `BOOT_PC;
        rst_n         = 1'b0;
        imem_ack_i    = 1'b0;
        imem_rdata_i  = '0;
        issue_ready_i = 1'b0;
        flush_i       = 1'b0;
        redirect_pc_i = '0;
        dep_mode      = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        reset_state();
        in_order_stream();
        dependency_split();
        backpressure_hold();
        flush_redirect();
        random_ready();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
